// File: source/memory_pkg.sv
package memory_pkg;

    // Byte lanes per 32-bit word
    localparam int NUM_LANES = 4;

    // One stored byte
    typedef logic [7:0] byte_t;

    // Addresses, load and store data, instructions
    typedef logic [31:0] word_t;

    // One write enable per byte lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Lane index, low two address bits
    typedef logic [1:0] lane_sel_t;

    // Store access size
    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } store_width_e;

endpackage : memory_pkg

// File: source/bank_if.sv
interface bank_if #(
    parameter int MEMORY_SIZE = 256
);

    localparam int ROW_W = $clog2(MEMORY_SIZE / memory_pkg::NUM_LANES);

    logic [ROW_W-1:0]     load_row;
    logic [ROW_W-1:0]     fetch_row;
    logic [ROW_W-1:0]     write_row;
    logic                 write_en;
    memory_pkg::byte_t    write_data;
    memory_pkg::byte_t    load_byte;   // Registered in the bank
    memory_pkg::byte_t    fetch_byte;  // Registered in the bank

    modport router (
        output load_row, fetch_row, write_row, write_en, write_data
    );

    modport bank (
        input  load_row, fetch_row, write_row, write_en, write_data,
        output load_byte, fetch_byte
    );

    modport assembler (
        input load_byte, fetch_byte
    );

endinterface : bank_if

// File: source/lane_router.sv
module lane_router #(
    parameter int MEMORY_SIZE = 256
) (
    input  memory_pkg::word_t        load_addr_i,
    input  memory_pkg::word_t        fetch_addr_i,
    input  memory_pkg::word_t        store_addr_i,
    input  memory_pkg::word_t        store_data_i,
    input  logic                     store_req_i,
    input  memory_pkg::store_width_e store_width_i,
    bank_if.router                   lanes [memory_pkg::NUM_LANES]
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);
    localparam int ROW_W  = ADDR_W - 2;

    memory_pkg::word_t      load_aligned;
    memory_pkg::word_t      fetch_aligned;
    memory_pkg::lane_sel_t  store_lane;
    memory_pkg::lane_mask_t width_mask;
    memory_pkg::lane_mask_t store_mask;
    logic [2*memory_pkg::NUM_LANES-1:0] mask_pair;
    logic [63:0]            data_pair;
    memory_pkg::word_t      store_rot;

    // Row holding byte 'lane' of the word starting at addr.
    // Lanes below the start lane spill into the next row, which wraps
    // at the top of the bank.
    function automatic logic [ROW_W-1:0] lane_row(
        input memory_pkg::word_t addr,
        input int unsigned       lane
    );
        logic [ROW_W-1:0]      base;
        memory_pkg::lane_sel_t start;
        base  = addr[ADDR_W-1:2];
        start = addr[1:0];
        if (lane < start) begin
            return base + 1'b1;  // Wraps naturally
        end
        return base;
    endfunction

    assign load_aligned  = {load_addr_i[31:2], 2'b00};  // Loads are word aligned
    assign fetch_aligned = {fetch_addr_i[31:1], 1'b0};  // Compressed code needs half words
    assign store_lane    = store_addr_i[1:0];

    // Lanes touched by a store starting at lane 0
    always_comb begin
        case (store_width_i)
            memory_pkg::BYTE:      width_mask = 4'b0001;
            memory_pkg::HALF_WORD: width_mask = 4'b0011;
            memory_pkg::WORD:      width_mask = 4'b1111;
            default:               width_mask = 4'b0000;
        endcase
    end

    // Rotate the mask onto the start lane, upper half holds the wrapped result
    assign mask_pair  = {width_mask, width_mask} << store_lane;
    assign store_mask = store_req_i ? mask_pair[7:4] : '0;

    // Byte k of the store data lands on lane (start + k) mod 4
    assign data_pair = {store_data_i, store_data_i} << {store_lane, 3'b000};
    assign store_rot = data_pair[63:32];

    for (genvar l = 0; l < memory_pkg::NUM_LANES; l++) begin : g_lane
        assign lanes[l].load_row   = lane_row(load_aligned, l);
        assign lanes[l].fetch_row  = lane_row(fetch_aligned, l);
        assign lanes[l].write_row  = lane_row(store_addr_i, l);
        assign lanes[l].write_en   = store_mask[l];
        assign lanes[l].write_data = store_rot[l*8 +: 8];
    end

    // Only the three defined widths may reach the banks
    always_comb begin
        if (store_req_i) begin
            assert (store_width_i inside {memory_pkg::BYTE, memory_pkg::HALF_WORD,
                                          memory_pkg::WORD})
                else $error("Illegal store width %0d", store_width_i);
        end
    end

endmodule : lane_router

// File: source/byte_bank.sv
module byte_bank #(
    parameter int MEMORY_SIZE = 256
) (
    input logic  clk_i,
    bank_if.bank lane
);

    localparam int DEPTH = MEMORY_SIZE / memory_pkg::NUM_LANES;

    memory_pkg::byte_t mem [DEPTH];

    // Memory starts cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Both read ports sample the array before this edge's write lands
    always_ff @(posedge clk_i) begin
        lane.load_byte  <= mem[lane.load_row];
        lane.fetch_byte <= mem[lane.fetch_row];
    end

    always_ff @(posedge clk_i) begin
        if (lane.write_en) begin
            mem[lane.write_row] <= lane.write_data;
        end
    end

    // A write needs a defined row from the router
    a_write_row_known : assert property (
        @(posedge clk_i) lane.write_en |-> !$isunknown(lane.write_row)
    ) else $error("Write enabled with an unknown row, data %h", lane.write_data);

endmodule : byte_bank

// File: source/word_assembler.sv
module word_assembler (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_req_i,
    input  logic                  store_req_i,
    input  logic                  fetch_i,
    input  logic                  invalidate_i,
    input  memory_pkg::lane_sel_t fetch_lane_i,  // Start lane of the fetch
    bank_if.assembler             lanes [memory_pkg::NUM_LANES],
    output memory_pkg::word_t     load_data_o,
    output logic                  load_valid_o,
    output logic                  store_done_o,
    output memory_pkg::word_t     fetch_instruction_o,
    output logic                  fetch_valid_o
);

    memory_pkg::word_t load_raw;
    memory_pkg::word_t fetch_raw;
    memory_pkg::word_t fetch_word;
    logic              fetch_upper_q;  // Fetch started on lane 2
    logic              hold_zero_q;

    // Gather the registered lane bytes, lane n in byte n
    for (genvar l = 0; l < memory_pkg::NUM_LANES; l++) begin : g_gather
        assign load_raw[l*8 +: 8]  = lanes[l].load_byte;
        assign fetch_raw[l*8 +: 8] = lanes[l].fetch_byte;
    end

    // Loads are word aligned, so lane order is byte order
    assign load_data_o = load_raw;

    // Half-word aligned fetch only ever starts on lane 0 or lane 2
    assign fetch_word = fetch_upper_q ? {fetch_raw[15:0], fetch_raw[31:16]} : fetch_raw;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_valid_o  <= 1'b0;
            store_done_o  <= 1'b0;
            fetch_valid_o <= 1'b0;
            fetch_upper_q <= 1'b0;
        end else begin
            load_valid_o  <= load_req_i;
            store_done_o  <= store_req_i;
            fetch_valid_o <= fetch_i && !invalidate_i;  // Flushed fetches stay invisible
            fetch_upper_q <= fetch_lane_i[1];
        end
    end

    // Instruction reads zero until the first clock out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_zero_q <= 1'b1;
        end else begin
            hold_zero_q <= 1'b0;
        end
    end

    // Follows the bank every cycle, valid or not
    assign fetch_instruction_o = hold_zero_q ? '0 : fetch_word;

    a_fetch_word_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_o |-> !$isunknown(fetch_instruction_o)
    ) else $error("Valid fetch returned unknown bits %h", fetch_instruction_o);

endmodule : word_assembler

// File: source/system_memory.sv
module system_memory #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Data channel, loads
    input  logic                     load_req_i,
    input  memory_pkg::word_t        load_addr_i,
    output memory_pkg::word_t        load_data_o,
    output logic                     load_valid_o,

    // Data channel, stores
    input  logic                     store_req_i,
    input  memory_pkg::word_t        store_addr_i,
    input  memory_pkg::store_width_e store_width_i,
    input  memory_pkg::word_t        store_data_i,
    output logic                     store_done_o,

    // Instruction channel
    input  logic                     fetch_i,
    input  logic                     invalidate_i,
    input  memory_pkg::word_t        fetch_addr_i,
    output memory_pkg::word_t        fetch_instruction_o,
    output logic                     fetch_valid_o
);

    bank_if #(.MEMORY_SIZE(MEMORY_SIZE)) lanes [memory_pkg::NUM_LANES] ();

    lane_router #(
        .MEMORY_SIZE(MEMORY_SIZE)
    ) lane_router_i (
        .load_addr_i   (load_addr_i),
        .fetch_addr_i  (fetch_addr_i),
        .store_addr_i  (store_addr_i),
        .store_data_i  (store_data_i),
        .store_req_i   (store_req_i),
        .store_width_i (store_width_i),
        .lanes         (lanes)
    );

    // One bank per byte lane
    for (genvar l = 0; l < memory_pkg::NUM_LANES; l++) begin : g_bank
        byte_bank #(
            .MEMORY_SIZE(MEMORY_SIZE)
        ) byte_bank_i (
            .clk_i (clk_i),
            .lane  (lanes[l])
        );
    end

    word_assembler word_assembler_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .load_req_i          (load_req_i),
        .store_req_i         (store_req_i),
        .fetch_i             (fetch_i),
        .invalidate_i        (invalidate_i),
        .fetch_lane_i        (fetch_addr_i[1:0]),
        .lanes               (lanes),
        .load_data_o         (load_data_o),
        .load_valid_o        (load_valid_o),
        .store_done_o        (store_done_o),
        .fetch_instruction_o (fetch_instruction_o),
        .fetch_valid_o       (fetch_valid_o)
    );

endmodule : system_memory

// File: test/memory_model.svh
`ifndef MEMORY_MODEL_SVH
`define MEMORY_MODEL_SVH

// Byte-addressed reference store, sized by MEM_SIZE of the including module
memory_pkg::byte_t model_mem [MEM_SIZE];

function automatic void clear_model();
    for (int i = 0; i < MEM_SIZE; i++) begin
        model_mem[i] = '0;
    end
endfunction

// Any address wraps onto the store
function automatic memory_pkg::byte_t read_byte(input memory_pkg::word_t addr);
    return model_mem[addr % MEM_SIZE];
endfunction

// Little endian word, byte k from address start + k
function automatic memory_pkg::word_t gather_word(input memory_pkg::word_t start);
    memory_pkg::word_t word;
    for (int k = 0; k < memory_pkg::NUM_LANES; k++) begin
        word[k*8 +: 8] = read_byte(start + memory_pkg::word_t'(k));
    end
    return word;
endfunction

function automatic memory_pkg::word_t expected_load(input memory_pkg::word_t addr);
    return gather_word(addr & ~32'h3);  // Word aligned
endfunction

function automatic memory_pkg::word_t expected_fetch(input memory_pkg::word_t addr);
    return gather_word(addr & ~32'h1);  // Half-word aligned
endfunction

// Store of one, two or four bytes at any alignment
function automatic void apply_store(
    input memory_pkg::word_t        addr,
    input memory_pkg::store_width_e width,
    input memory_pkg::word_t        data
);
    int                count;
    memory_pkg::word_t idx;
    case (width)
        memory_pkg::BYTE:      count = 1;
        memory_pkg::HALF_WORD: count = 2;
        default:               count = 4;
    endcase
    for (int k = 0; k < count; k++) begin
        idx = addr + memory_pkg::word_t'(k);
        model_mem[idx % MEM_SIZE] = data[k*8 +: 8];
    end
endfunction

`endif

// File: test/system_memory_tb.sv
module system_memory_tb;

    localparam int MEM_SIZE        = 256;
    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 64;    // Upper bound for tests 1 to 4
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int WATCHDOG_TIME   = 2 * TOTAL_CYCLES * CLK_PERIOD;
    localparam logic [31:0] SEED   = 32'haf86_2396;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     load_req_i;
    memory_pkg::word_t        load_addr_i;
    memory_pkg::word_t        load_data_o;
    logic                     load_valid_o;
    logic                     store_req_i;
    memory_pkg::word_t        store_addr_i;
    memory_pkg::store_width_e store_width_i;
    memory_pkg::word_t        store_data_i;
    logic                     store_done_o;
    logic                     fetch_i;
    logic                     invalidate_i;
    memory_pkg::word_t        fetch_addr_i;
    memory_pkg::word_t        fetch_instruction_o;
    logic                     fetch_valid_o;

    int checks;
    int errors;
    int errors_at_start;

    `include "memory_model.svh"

    system_memory #(
        .MEMORY_SIZE(MEM_SIZE)
    ) system_memory_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .load_req_i          (load_req_i),
        .load_addr_i         (load_addr_i),
        .load_data_o         (load_data_o),
        .load_valid_o        (load_valid_o),
        .store_req_i         (store_req_i),
        .store_addr_i        (store_addr_i),
        .store_width_i       (store_width_i),
        .store_data_i        (store_data_i),
        .store_done_o        (store_done_o),
        .fetch_i             (fetch_i),
        .invalidate_i        (invalidate_i),
        .fetch_addr_i        (fetch_addr_i),
        .fetch_instruction_o (fetch_instruction_o),
        .fetch_valid_o       (fetch_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d mismatches", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Drives one cycle of requests and checks the responses one edge later
    task automatic issue(
        input logic                     ld,
        input memory_pkg::word_t        ld_addr,
        input logic                     st,
        input memory_pkg::word_t        st_addr,
        input memory_pkg::store_width_e width,
        input memory_pkg::word_t        st_data,
        input logic                     fe,
        input logic                     inv,
        input memory_pkg::word_t        fe_addr
    );
        memory_pkg::word_t exp_load;
        memory_pkg::word_t exp_fetch;
        exp_load  = expected_load(ld_addr);    // Reads see the old bytes
        exp_fetch = expected_fetch(fe_addr);
        load_req_i    = ld;
        load_addr_i   = ld_addr;
        store_req_i   = st;
        store_addr_i  = st_addr;
        store_width_i = width;
        store_data_i  = st_data;
        fetch_i       = fe;
        invalidate_i  = inv;
        fetch_addr_i  = fe_addr;
        if (st) begin
            apply_store(st_addr, width, st_data);
        end
        @(posedge clk_i);
        #(DRIVE_DELAY);
        checks += 3 + int'(ld) + int'(fe);
        if (load_valid_o !== ld)
            flag_mismatch($sformatf("load_valid_o is %b, expected %b", load_valid_o, ld));
        if (ld && load_data_o !== exp_load)
            flag_mismatch($sformatf("load at %h gave %h, expected %h",
                                    ld_addr, load_data_o, exp_load));
        if (store_done_o !== st)
            flag_mismatch($sformatf("store_done_o is %b, expected %b", store_done_o, st));
        if (fetch_valid_o !== (fe && !inv))
            flag_mismatch($sformatf("fetch_valid_o is %b, expected %b",
                                    fetch_valid_o, fe && !inv));
        if (fe && fetch_instruction_o !== exp_fetch)
            flag_mismatch($sformatf("fetch at %h gave %h, expected %h",
                                    fe_addr, fetch_instruction_o, exp_fetch));
    endtask

    // Requests stay high through reset and must not show up afterwards
    task automatic reset_and_check(input memory_pkg::word_t addr);
        rst_n_i      = 1'b0;
        load_req_i   = 1'b1;
        load_addr_i  = addr;
        store_req_i  = 1'b0;
        fetch_i      = 1'b1;
        fetch_addr_i = addr;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_n_i    = 1'b1;
        load_req_i = 1'b0;
        fetch_i    = 1'b0;
        checks += 4;
        if (load_valid_o !== 1'b0) flag_mismatch("load_valid_o high after reset");
        if (store_done_o !== 1'b0) flag_mismatch("store_done_o high after reset");
        if (fetch_valid_o !== 1'b0) flag_mismatch("fetch_valid_o high after reset");
        if (fetch_instruction_o !== '0) flag_mismatch("fetch_instruction_o not zero after reset");
    endtask

    task automatic do_store(input memory_pkg::word_t addr, input memory_pkg::store_width_e width,
                            input memory_pkg::word_t data);
        issue(1'b0, '0, 1'b1, addr, width, data, 1'b0, 1'b0, '0);
    endtask

    task automatic do_load(input memory_pkg::word_t addr);
        issue(1'b1, addr, 1'b0, '0, memory_pkg::BYTE, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic do_fetch(input memory_pkg::word_t addr, input logic inv);
        issue(1'b0, '0, 1'b0, '0, memory_pkg::BYTE, '0, 1'b1, inv, addr);
    endtask

    // Window of 16 bytes around address zero, upper bits random
    function automatic memory_pkg::word_t window_addr();
        memory_pkg::word_t low;
        low = (32'hF8 + $urandom_range(15, 0)) & 32'hFF;
        return ($urandom & 32'hFFFF_FF00) | low;
    endfunction

    initial begin
        checks          = 0;
        errors          = 0;
        errors_at_start = 0;
        void'($urandom(SEED));
        clear_model();
        rst_n_i       = 1'b0;
        load_req_i    = 1'b0;
        load_addr_i   = '0;
        store_req_i   = 1'b0;
        store_addr_i  = '0;
        store_width_i = memory_pkg::BYTE;
        store_data_i  = '0;
        fetch_i       = 1'b0;
        invalidate_i  = 1'b0;
        fetch_addr_i  = '0;
        reset_and_check('0);
        finish_test("reset");

        do_store(32'h40, memory_pkg::WORD, $urandom);
        do_load(32'h40);
        do_load(32'h43);                                    // Forced to word alignment
        issue(1'b0, '0, 1'b0, '0, memory_pkg::BYTE, '0, 1'b0, 1'b0, '0);
        finish_test("word store and load");

        for (int off = 0; off < 4; off++) begin
            do_store(32'h80 + off, memory_pkg::BYTE, $urandom);
            do_load(32'h80);
            do_store(32'h91 + off, memory_pkg::HALF_WORD, $urandom);  // 0x94 crosses a row
            do_load(32'h90 + off);
            do_load(32'h94);
        end
        do_store(32'd254, memory_pkg::WORD, $urandom);    // Wraps to address 0
        do_load(32'd252);
        do_load(32'd0);
        finish_test("byte and half-word stores");

        for (int a = 32'h10; a < 32'h20; a += 4) begin
            do_store(a, memory_pkg::WORD, $urandom);
        end
        do_fetch(32'h10, 1'b0);
        do_fetch(32'h12, 1'b0);
        do_fetch(32'h17, 1'b0);                             // Forced to half-word alignment
        do_fetch(32'h1E, 1'b0);
        do_fetch(32'h12, 1'b1);                             // Flushed, data still checked
        do_fetch(32'd254, 1'b0);
        finish_test("fetch");

        reset_and_check(32'h10);                            // Banks keep their data
        finish_test("reset with stored data");

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            issue($urandom_range(1, 0) == 1, window_addr(),
                  $urandom_range(1, 0) == 1, window_addr(),
                  memory_pkg::store_width_e'($urandom_range(2, 0)), $urandom,
                  $urandom_range(1, 0) == 1, $urandom_range(3, 0) == 0, window_addr());
        end
        finish_test("random traffic");

        $display("Summary: %0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : system_memory_tb

// File: system_memory.f
+incdir+test
source/memory_pkg.sv
source/bank_if.sv
source/lane_router.sv
source/byte_bank.sv
source/word_assembler.sv
source/system_memory.sv
test/system_memory_tb.sv

// File: Makefile
# Verilator flow for the unified system memory

SHELL      := /bin/bash

VERILATOR  ?= verilator
TOP        ?= system_memory_tb
RTL_TOP    ?= system_memory
FILELIST   ?= system_memory.f
BUILD_DIR  ?= build
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --assert
SIM_FLAGS  ?= --binary --assert -Wno-fatal
FAIL_TEXT  ?= CHECKS FAILED

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
